// ==== rv_core.f ====
hw/core_pkg.sv
hw/regfile.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_top.sv
tb/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hw/core_pkg.sv
  - hw/regfile.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/core_top.sv
  - target: test
    files:
      - tb/core_tb.sv

// ==== tb/core_tb.sv ====
// Testbench for rv_core: clock and reset, a small assembled program,
// instruction and data bus models with random ready delays,
// a golden model stepped per commit, and assertions on commits,
// data accesses and bus request stability
`timescale 1ns/10ps
`default_nettype none

module core_tb;

  localparam int          clock_period   = 40;
  localparam int          drive_delay    = 2;
  localparam int          reset_cycles   = 16;
  localparam int          max_commits    = 200;
  localparam int          worst_bus_wait = 4;
  localparam int          timeout_cycles = reset_cycles + max_commits * 4 * worst_bus_wait + 1000;
  localparam int          prog_words     = 32;
  localparam logic [63:0] start_pc       = 64'h200;
  localparam logic [31:0] nop_word       = 32'h0000_0013;

  typedef struct packed {
    logic [63:0] pc;
    logic        writes_rd;
    logic [4:0]  rd;
    logic [63:0] data;
    logic        access;
    logic        store;
    logic [63:0] addr;
    logic [63:0] wdata;
  } expect_t;

  logic               clock;
  logic               reset;
  logic               imem_valid;
  core_pkg::mem_req_t imem_req;
  logic               imem_ready;
  logic [31:0]        imem_rdata;
  logic               dmem_valid;
  core_pkg::mem_req_t dmem_req;
  logic               dmem_ready;
  logic [63:0]        dmem_rdata;
  core_pkg::commit_t  commit;

  logic [31:0]        program_mem [prog_words];
  logic [63:0]        data_mem [64];
  logic [63:0]        g_mem [64];
  logic [63:0]        g_regs [32];
  logic [63:0]        g_pc;
  int                 commits;
  int                 errors;
  logic               seen_fetch;
  logic               imem_waiting;
  logic               dmem_waiting;
  core_pkg::mem_req_t held_imem;
  core_pkg::mem_req_t held_dmem;

  core_top #(.reset_pc(start_pc)) dut_i (
    .clock, .reset, .imem_valid, .imem_req, .imem_ready, .imem_rdata,
    .dmem_valid, .dmem_req, .dmem_ready, .dmem_rdata, .commit
  );

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      errors++;
      $display("error at %0t: %s", $time, what);
      stop_run();
    end
  endtask

  function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, core_pkg::opc_op};
  endfunction

  function automatic logic [31:0] s_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], core_pkg::opc_store};
  endfunction

  function automatic logic [31:0] b_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], core_pkg::opc_branch};
  endfunction

  function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::opc_jal};
  endfunction

  function automatic logic [31:0] program_word(input logic [63:0] addr);
    logic [63:0] offset;
    offset = addr - start_pc;
    if (addr < start_pc || offset[63:2] >= prog_words)
      return nop_word;
    return program_mem[offset[6:2]];
  endfunction

  // initial memory contents vary with every address bit
  function automatic logic [63:0] fill_value(input logic [63:0] addr);
    return 64'h5a5a_0000_0000_0000 ^ (addr * 64'h0001_0001_0001_0001);
  endfunction

  task automatic load_program();
    for (int i = 0; i < prog_words; i++)
      program_mem[i] = nop_word;
    // dependent arithmetic chain
    program_mem[0]  = i_word(core_pkg::opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd5);
    program_mem[1]  = i_word(core_pkg::opc_op_imm, 3'b000, 5'd2, 5'd1, 12'd7);
    program_mem[2]  = r_word(7'h00, 5'd2, 5'd1, 5'd3);
    program_mem[3]  = r_word(7'h20, 5'd1, 5'd3, 5'd4);
    program_mem[4]  = r_word(7'h00, 5'd4, 5'd4, 5'd5);
    // store then load of the same doubleword
    program_mem[5]  = i_word(core_pkg::opc_op_imm, 3'b000, 5'd6, 5'd0, 12'd16);
    program_mem[6]  = s_word(5'd5, 5'd6, 12'd8);
    program_mem[7]  = i_word(core_pkg::opc_load, 3'b011, 5'd7, 5'd6, 12'd8);
    program_mem[8]  = r_word(7'h00, 5'd7, 5'd7, 5'd8);
    // x0 written, then read back as zero
    program_mem[9]  = i_word(core_pkg::opc_op_imm, 3'b000, 5'd0, 5'd1, 12'd99);
    program_mem[10] = r_word(7'h00, 5'd1, 5'd0, 5'd9);
    // taken BEQ skips two, not-taken falls through, JAL skips two
    program_mem[11] = b_word(5'd7, 5'd5, 13'd12);
    program_mem[12] = i_word(core_pkg::opc_op_imm, 3'b000, 5'd10, 5'd0, 12'd1);
    program_mem[13] = i_word(core_pkg::opc_op_imm, 3'b000, 5'd10, 5'd0, 12'd2);
    program_mem[14] = b_word(5'd1, 5'd2, 13'd8);
    program_mem[15] = j_word(5'd11, 21'd12);
    program_mem[16] = i_word(core_pkg::opc_op_imm, 3'b000, 5'd12, 5'd0, 12'd3);
    program_mem[17] = i_word(core_pkg::opc_op_imm, 3'b000, 5'd12, 5'd0, 12'd4);
    program_mem[18] = r_word(7'h20, 5'd1, 5'd0, 5'd13);
    program_mem[19] = s_word(5'd13, 5'd6, -12'sd8);
    program_mem[20] = i_word(core_pkg::opc_load, 3'b011, 5'd14, 5'd6, -12'sd8);
    program_mem[21] = i_word(core_pkg::opc_op_imm, 3'b000, 5'd15, 5'd14, -12'sd3);
    program_mem[22] = i_word(core_pkg::opc_load, 3'b011, 5'd16, 5'd6, 12'd0);
    program_mem[23] = r_word(7'h00, 5'd15, 5'd16, 5'd17);
    program_mem[24] = b_word(5'd0, 5'd0, 13'd8);
    program_mem[25] = i_word(core_pkg::opc_op_imm, 3'b000, 5'd18, 5'd0, 12'd9);
    program_mem[26] = j_word(5'd0, 21'd0);
  endtask

  // steps the architectural state to the next committing instruction
  task automatic golden_next(output expect_t e);
    logic [31:0] w;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic        found;
    found = 1'b0;
    e = '0;
    while (!found) begin
      w = program_word(g_pc);
      a = g_regs[w[19:15]];
      b = g_regs[w[24:20]];
      imm_i = {{52{w[31]}}, w[31:20]};
      imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      e = '0;
      e.pc = g_pc;
      e.rd = w[11:7];
      found = 1'b1;
      g_pc = g_pc + 64'd4;
      case (w[6:0])
        core_pkg::opc_op_imm: begin
          e.writes_rd = 1'b1;
          e.data = a + imm_i;
        end
        core_pkg::opc_op: begin
          e.writes_rd = 1'b1;
          e.data = w[30] ? a - b : a + b;
        end
        core_pkg::opc_load: begin
          e.writes_rd = 1'b1;
          e.access = 1'b1;
          e.addr = a + imm_i;
          e.data = g_mem[e.addr[8:3]];
        end
        core_pkg::opc_store: begin
          e.access = 1'b1;
          e.store = 1'b1;
          e.addr = a + imm_s;
          e.wdata = b;
          g_mem[e.addr[8:3]] = b;
        end
        core_pkg::opc_branch: begin
          found = 1'b0;
          if (a == b)
            g_pc = e.pc + imm_b;
        end
        core_pkg::opc_jal: begin
          e.writes_rd = 1'b1;
          e.data = e.pc + 64'd4;
          g_pc = e.pc + imm_j;
        end
        default: require(1'b0, "golden model reached an unsupported instruction");
      endcase
      if (e.writes_rd && e.rd != 5'd0)
        g_regs[e.rd] = e.data;
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    commits = 0;
    errors = 0;
    seen_fetch = 1'b0;
    imem_waiting = 1'b0;
    dmem_waiting = 1'b0;
    g_pc = start_pc;
    load_program();
    for (int i = 0; i < 32; i++)
      g_regs[i] = '0;
    for (int i = 0; i < 64; i++) begin
      data_mem[i] = fill_value(64'(i) * 64'd8);
      g_mem[i] = fill_value(64'(i) * 64'd8);
    end
    repeat (reset_cycles) @(posedge clock);
    #drive_delay;
    reset = 1'b0;
    wait (commits >= max_commits);
    if (errors == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_run();
    end
  end

  initial begin
    #(timeout_cycles * clock_period);
    $display("timeout: %0d of %0d commits seen", commits, max_commits);
    stop_run();
  end

  // bus slaves raise ready after 0 to 3 wait cycles per request
  initial begin : bus_models
    int unsigned imem_wait;
    int unsigned dmem_wait;
    logic        imem_busy;
    logic        dmem_busy;
    void'($urandom(32'h7a18));
    imem_ready = 1'b0;
    imem_rdata = '0;
    dmem_ready = 1'b0;
    dmem_rdata = '0;
    imem_busy = 1'b0;
    dmem_busy = 1'b0;
    imem_wait = 0;
    dmem_wait = 0;
    forever begin
      @(posedge clock);
      #drive_delay;
      if (imem_ready || reset)
        imem_busy = 1'b0;
      if (dmem_ready || reset)
        dmem_busy = 1'b0;
      imem_ready = 1'b0;
      dmem_ready = 1'b0;
      if (imem_valid === 1'b1 && !reset) begin
        if (!imem_busy) begin
          imem_busy = 1'b1;
          imem_wait = $urandom % 4;
        end
        if (imem_wait == 0) begin
          imem_ready = 1'b1;
          imem_rdata = program_word(imem_req.addr);
        end else begin
          imem_wait--;
        end
      end
      if (dmem_valid === 1'b1 && !reset) begin
        if (!dmem_busy) begin
          dmem_busy = 1'b1;
          dmem_wait = $urandom % 4;
        end
        if (dmem_wait == 0) begin
          dmem_ready = 1'b1;
          if (dmem_req.write)
            data_mem[dmem_req.addr[8:3]] = dmem_req.wdata;
          else
            dmem_rdata = data_mem[dmem_req.addr[8:3]];
        end else begin
          dmem_wait--;
        end
      end
    end
  end

  // sampled mid-cycle when all outputs have settled
  always @(negedge clock) begin : check_cycle
    expect_t e;
    if (reset) begin
      require(!imem_valid && !dmem_valid && !commit.valid,
              "bus request or commit active during reset");
    end else begin
      if (imem_valid && !seen_fetch) begin
        compare_value("imem_req.addr", imem_req.addr, start_pc);
        seen_fetch = 1'b1;
      end
      if (imem_valid)
        compare_value("imem_req.write", imem_req.write, 1'b0);
      if (imem_waiting) begin
        require(imem_valid, "imem_valid fell before imem_ready");
        compare_value("imem_req.addr", imem_req.addr, held_imem.addr);
        compare_value("imem_req.write", imem_req.write, held_imem.write);
        compare_value("imem_req.wdata", imem_req.wdata, held_imem.wdata);
      end
      if (dmem_waiting) begin
        require(dmem_valid, "dmem_valid fell before dmem_ready");
        compare_value("dmem_req.addr", dmem_req.addr, held_dmem.addr);
        compare_value("dmem_req.write", dmem_req.write, held_dmem.write);
        compare_value("dmem_req.wdata", dmem_req.wdata, held_dmem.wdata);
      end
      if (commit.valid) begin
        golden_next(e);
        compare_value("commit.pc", commit.pc, e.pc);
        compare_value("commit.writes_rd", commit.writes_rd, e.writes_rd);
        if (e.writes_rd) begin
          compare_value("commit.rd", commit.rd, e.rd);
          compare_value("commit.data", commit.data, e.data);
        end
        commits++;
      end
      if (dmem_valid && dmem_ready) begin
        require(commit.valid && e.access,
                "data access completed with no load or store retiring");
        compare_value("dmem_req.addr", dmem_req.addr, e.addr);
        compare_value("dmem_req.write", dmem_req.write, e.store);
        if (e.store)
          compare_value("dmem_req.wdata", dmem_req.wdata, e.wdata);
      end
      imem_waiting = imem_valid && !imem_ready;
      dmem_waiting = dmem_valid && !dmem_ready;
      held_imem = imem_req;
      held_dmem = dmem_req;
    end
  end

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
// rv_core top level: fetch, decode, execute and memory stages
// with the register file beside decode
`timescale 1ns/10ps
`default_nettype none

module core_top #(
  parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                      clock,
  input  logic                      reset,
  output logic                      imem_valid,
  output core_pkg::mem_req_t        imem_req,
  input  logic                      imem_ready,
  input  logic [31:0]               imem_rdata,
  output logic                      dmem_valid,
  output core_pkg::mem_req_t        dmem_req,
  input  logic                      dmem_ready,
  input  logic [core_pkg::xlen-1:0] dmem_rdata,
  output core_pkg::commit_t         commit
);

  logic                      if_to_id_valid;
  logic                      id_to_ex_valid;
  logic                      ex_to_mem_valid;
  logic                      id_allowin;
  logic                      ex_allowin;
  logic                      mem_allowin;
  core_pkg::fd_t             if_to_id;
  core_pkg::dx_t             id_to_ex;
  core_pkg::xm_t             ex_to_mem;
  core_pkg::redirect_t       redirect;
  logic [4:0]                rs1_addr;
  logic [4:0]                rs2_addr;
  logic [core_pkg::xlen-1:0] rs1_data;
  logic [core_pkg::xlen-1:0] rs2_data;
  logic                      reg_write;
  logic [4:0]                reg_rd;
  logic [core_pkg::xlen-1:0] reg_data;

  fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .clock, .reset, .id_allowin, .redirect, .imem_ready, .imem_rdata,
    .if_to_id_valid, .if_to_id, .imem_valid, .imem_req
  );

  decode_stage u_decode (
    .clock, .reset, .if_to_id_valid, .if_to_id, .ex_allowin,
    .flush(redirect.taken), .rs1_data, .rs2_data,
    .wb_write(reg_write), .wb_rd(reg_rd),
    .id_allowin, .id_to_ex_valid, .id_to_ex, .rs1_addr, .rs2_addr
  );

  execute_stage u_execute (
    .clock, .reset, .id_to_ex_valid, .id_to_ex, .mem_allowin,
    .ex_allowin, .ex_to_mem_valid, .ex_to_mem, .redirect
  );

  memory_stage u_memory (
    .clock, .reset, .ex_to_mem_valid, .ex_to_mem, .dmem_ready, .dmem_rdata,
    .mem_allowin, .dmem_valid, .dmem_req, .reg_write, .reg_rd, .reg_data, .commit
  );

  regfile u_regfile (
    .clock, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .write(reg_write), .rd(reg_rd), .data(reg_data)
  );

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
// Memory stage: data bus master for LD and SD, register file
// writeback and the commit record of each retiring instruction
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      ex_to_mem_valid,
  input  core_pkg::xm_t             ex_to_mem,
  input  logic                      dmem_ready,
  input  logic [core_pkg::xlen-1:0] dmem_rdata,
  output logic                      mem_allowin,
  output logic                      dmem_valid,
  output core_pkg::mem_req_t        dmem_req,
  output logic                      reg_write,
  output logic [4:0]                reg_rd,
  output logic [core_pkg::xlen-1:0] reg_data,
  output core_pkg::commit_t         commit
);

  logic access;
  logic ready_go;
  logic leave;

  assign access = ex_to_mem.is_load || ex_to_mem.is_store;
  // request is held by the execute register until ready
  assign dmem_valid = ex_to_mem_valid && access;
  assign dmem_req = '{
    addr:  ex_to_mem.result,
    write: ex_to_mem.is_store,
    wdata: ex_to_mem.store_data
  };

  assign ready_go = !access || dmem_ready;
  assign mem_allowin = !ex_to_mem_valid || ready_go;
  assign leave = ex_to_mem_valid && ready_go;

  assign reg_write = leave && ex_to_mem.writes_rd;
  assign reg_rd = ex_to_mem.rd;
  assign reg_data = ex_to_mem.is_load ? dmem_rdata : ex_to_mem.result;

  // BEQ is the only item that neither writes nor stores
  assign commit = '{
    valid:     leave && (ex_to_mem.writes_rd || ex_to_mem.is_store),
    pc:        ex_to_mem.pc,
    writes_rd: ex_to_mem.writes_rd,
    rd:        ex_to_mem.rd,
    data:      reg_data
  };

  a_dmem_stable: assert property (@(posedge clock) disable iff (reset)
    dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_req));

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
// Execute stage: add/sub ALU, address and link computation,
// BEQ equality, redirect to fetch and the execute-to-memory register
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                id_to_ex_valid,
  input  core_pkg::dx_t       id_to_ex,
  input  logic                mem_allowin,
  output logic                ex_allowin,
  output logic                ex_to_mem_valid,
  output core_pkg::xm_t       ex_to_mem,
  output core_pkg::redirect_t redirect
);

  logic [core_pkg::xlen-1:0] result;
  logic                      equal;
  logic                      move;
  logic                      take;

  assign result = (id_to_ex.alu_op == core_pkg::alu_sub) ?
                  id_to_ex.operand_a - id_to_ex.operand_b :
                  id_to_ex.operand_a + id_to_ex.operand_b;
  assign equal = (result == '0);

  assign ex_allowin = !ex_to_mem_valid || mem_allowin;
  assign move = id_to_ex_valid && ex_allowin;
  // redirect only once the item is handed to memory
  assign take = move && (id_to_ex.is_jal || (id_to_ex.is_branch && equal));

  assign redirect = '{taken: take, target: id_to_ex.pc + id_to_ex.imm};

  always_ff @(posedge clock) begin
    if (reset)
      ex_to_mem_valid <= 1'b0;
    else if (ex_allowin)
      ex_to_mem_valid <= id_to_ex_valid;
  end

  // branches travel on with no register write
  always_ff @(posedge clock) begin
    if (move) begin
      ex_to_mem.pc <= id_to_ex.pc;
      ex_to_mem.result <= result;
      ex_to_mem.store_data <= id_to_ex.store_data;
      ex_to_mem.rd <= id_to_ex.rd;
      ex_to_mem.is_load <= id_to_ex.is_load;
      ex_to_mem.is_store <= id_to_ex.is_store;
      ex_to_mem.writes_rd <= id_to_ex.writes_rd;
    end
  end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
// Decode stage: field extraction through the instruction union,
// immediate sign extension, operand selection, register read addresses,
// scoreboard hazard stall and the decode-to-execute register
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      if_to_id_valid,
  input  core_pkg::fd_t             if_to_id,
  input  logic                      ex_allowin,
  input  logic                      flush,
  input  logic [core_pkg::xlen-1:0] rs1_data,
  input  logic [core_pkg::xlen-1:0] rs2_data,
  input  logic                      wb_write,
  input  logic [4:0]                wb_rd,
  output logic                      id_allowin,
  output logic                      id_to_ex_valid,
  output core_pkg::dx_t             id_to_ex,
  output logic [4:0]                rs1_addr,
  output logic [4:0]                rs2_addr
);

  core_pkg::inst_t           inst;
  core_pkg::dx_t             dx_next;
  logic [core_pkg::xlen-1:0] imm_i;
  logic [core_pkg::xlen-1:0] imm_s;
  logic [core_pkg::xlen-1:0] imm_b;
  logic [core_pkg::xlen-1:0] imm_j;
  logic                      use_rs1;
  logic                      use_rs2;
  logic [31:0]               scoreboard;
  logic [31:0]               clear_mask;
  logic [31:0]               set_mask;
  logic [31:0]               busy;
  logic                      hazard;
  logic                      dx_allowin;
  logic                      move;

  assign inst = if_to_id.inst;
  assign rs1_addr = inst.r_fmt.rs1;
  assign rs2_addr = inst.r_fmt.rs2;

  assign imm_i = {{52{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{52{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_b = {{51{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                  inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
  assign imm_j = {{43{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    dx_next = '0;
    dx_next.pc = if_to_id.pc;
    dx_next.rd = inst.r_fmt.rd;
    dx_next.alu_op = core_pkg::alu_add;
    dx_next.operand_a = rs1_data;
    dx_next.operand_b = rs2_data;
    dx_next.store_data = rs2_data;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (inst.r_fmt.opcode)
      core_pkg::opc_op_imm: begin
        use_rs1 = 1'b1;
        dx_next.operand_b = imm_i;
        dx_next.imm = imm_i;
        dx_next.writes_rd = 1'b1;
      end
      core_pkg::opc_op: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        dx_next.writes_rd = 1'b1;
        if (inst.r_fmt.funct7[5])
          dx_next.alu_op = core_pkg::alu_sub;
      end
      core_pkg::opc_load: begin
        use_rs1 = 1'b1;
        dx_next.operand_b = imm_i;
        dx_next.imm = imm_i;
        dx_next.is_load = 1'b1;
        dx_next.writes_rd = 1'b1;
      end
      core_pkg::opc_store: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        dx_next.operand_b = imm_s;
        dx_next.imm = imm_s;
        dx_next.is_store = 1'b1;
      end
      core_pkg::opc_branch: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        dx_next.alu_op = core_pkg::alu_sub;
        dx_next.imm = imm_b;
        dx_next.is_branch = 1'b1;
      end
      core_pkg::opc_jal: begin
        // link value pc + 4 comes out of the ALU
        dx_next.operand_a = if_to_id.pc;
        dx_next.operand_b = 64'd4;
        dx_next.imm = imm_j;
        dx_next.is_jal = 1'b1;
        dx_next.writes_rd = 1'b1;
      end
      default: ;
    endcase
  end

  // a register written back this cycle is already readable via write-through
  assign clear_mask = wb_write ? (32'd1 << wb_rd) : 32'd0;
  assign busy = scoreboard & ~clear_mask;
  assign hazard = if_to_id_valid && ((use_rs1 && busy[rs1_addr]) ||
                  (use_rs2 && busy[rs2_addr]) || (dx_next.writes_rd && busy[dx_next.rd]));

  assign dx_allowin = !id_to_ex_valid || ex_allowin;
  assign id_allowin = dx_allowin && !hazard;
  assign move = if_to_id_valid && id_allowin && !flush;
  assign set_mask = (move && dx_next.writes_rd && dx_next.rd != 5'd0) ?
                    (32'd1 << dx_next.rd) : 32'd0;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_to_ex_valid <= 1'b0;
      scoreboard <= '0;
    end else begin
      if (flush)
        id_to_ex_valid <= 1'b0;
      else if (dx_allowin)
        id_to_ex_valid <= if_to_id_valid && !hazard;
      scoreboard <= busy | set_mask;
    end
  end

  always_ff @(posedge clock) begin
    if (move)
      id_to_ex <= dx_next;
  end

  a_single_writer: assert property (@(posedge clock) disable iff (reset)
    (|set_mask) |-> (set_mask & busy) == 32'd0);

  a_wb_tracked: assert property (@(posedge clock) disable iff (reset)
    wb_write && wb_rd != 5'd0 |-> scoreboard[wb_rd]);

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
// Fetch stage: PC register, instruction bus master with one
// outstanding request, redirect handling and the fetch-to-decode register
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
  parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      id_allowin,
  input  core_pkg::redirect_t       redirect,
  input  logic                      imem_ready,
  input  logic [31:0]               imem_rdata,
  output logic                      if_to_id_valid,
  output core_pkg::fd_t             if_to_id,
  output logic                      imem_valid,
  output core_pkg::mem_req_t        imem_req
);

  logic [core_pkg::xlen-1:0] pc;
  logic [core_pkg::xlen-1:0] req_addr;
  logic [core_pkg::xlen-1:0] next_pc;
  logic                      drop;
  logic                      slot_free;
  logic                      issue;
  logic                      accept;

  assign next_pc = redirect.taken ? redirect.target : pc;
  // the fd register is empty next cycle, so returning data has a home
  assign slot_free = !if_to_id_valid || id_allowin;
  assign issue = !imem_valid && slot_free;
  assign accept = imem_valid && imem_ready && !drop && !redirect.taken;

  assign imem_req = '{addr: req_addr, write: 1'b0, wdata: '0};

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
      imem_valid <= 1'b0;
      drop <= 1'b0;
      if_to_id_valid <= 1'b0;
    end else begin
      if (issue) begin
        imem_valid <= 1'b1;
        pc <= next_pc + 64'd4;
      end else begin
        pc <= next_pc;
        if (imem_valid && imem_ready)
          imem_valid <= 1'b0;
      end
      // stale request still on the bus after a redirect
      if (imem_valid && imem_ready)
        drop <= 1'b0;
      else if (imem_valid && redirect.taken)
        drop <= 1'b1;
      if (redirect.taken)
        if_to_id_valid <= 1'b0;
      else if (accept)
        if_to_id_valid <= 1'b1;
      else if (id_allowin)
        if_to_id_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue)
      req_addr <= next_pc;
    if (accept) begin
      if_to_id.pc <= req_addr;
      if_to_id.inst <= imem_rdata;
    end
  end

  a_imem_stable: assert property (@(posedge clock) disable iff (reset)
    imem_valid && !imem_ready |=> imem_valid && $stable(imem_req));

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
// Integer register file: 32 x 64 bits, two read ports with
// write-through, one write port, x0 reads as zero
`timescale 1ns/10ps
`default_nettype none

module regfile (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [4:0]                rs1_addr,
  input  logic [4:0]                rs2_addr,
  output logic [core_pkg::xlen-1:0] rs1_data,
  output logic [core_pkg::xlen-1:0] rs2_data,
  input  logic                      write,
  input  logic [4:0]                rd,
  input  logic [core_pkg::xlen-1:0] data
);

  logic [core_pkg::xlen-1:0] regs [32];

  function automatic logic [core_pkg::xlen-1:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0)
      return '0;
    else if (write && rd == addr)
      return data;
    else
      return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (write && rd != 5'd0) begin
      regs[rd] <= data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
// Shared types and constants for the rv_core pipeline:
// instruction formats and the instruction union,
// RV64I opcodes of the supported subset,
// stage payload structs, redirect, commit and bus request.
`default_nettype none

package core_pkg;

  localparam int xlen = 64;

  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered over the word
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } inst_t;

  typedef enum logic [0:0] {
    alu_add,
    alu_sub
  } alu_op_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
  } fd_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] imm;
    logic [4:0]      rd;
    alu_op_t         alu_op;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            is_jal;
    logic            writes_rd;
  } dx_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] result;
    logic [xlen-1:0] store_data;
    logic [4:0]      rd;
    logic            is_load;
    logic            is_store;
    logic            writes_rd;
  } xm_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic            writes_rd;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } commit_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic            write;
    logic [xlen-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire
